/* hw/alu.sv */
`timescale 1ns/100ps

module alu (
    input  cpu_isa_pkg::alu_op_t alu_op,
    input  cpu_isa_pkg::byte_t   alu_a,
    input  cpu_isa_pkg::byte_t   alu_b,
    input  logic                 carry_in,
    output cpu_isa_pkg::byte_t   result,
    output logic                 z,
    output logic                 n,
    output logic                 h,
    output logic                 c
);
    import cpu_isa_pkg::*;

    logic       cin;
    logic [8:0] full;
    logic [4:0] half;   // Low nibble, bit 4 is the half carry or borrow

    assign cin = (alu_op == alu_adc || alu_op == alu_sbc) ? carry_in : 1'b0;

    always_comb
    begin
        full   = 9'd0;
        half   = 5'd0;
        result = 8'h00;
        h      = 1'b0;
        c      = 1'b0;
        case (alu_op)
            alu_add, alu_adc:
            begin
                full   = {1'b0, alu_a} + {1'b0, alu_b} + {8'd0, cin};
                half   = {1'b0, alu_a[3:0]} + {1'b0, alu_b[3:0]} + {4'd0, cin};
                result = full[7:0];
                h      = half[4];
                c      = full[8];
            end
            alu_sub, alu_sbc, alu_cp:
            begin
                full   = {1'b0, alu_a} - {1'b0, alu_b} - {8'd0, cin};
                half   = {1'b0, alu_a[3:0]} - {1'b0, alu_b[3:0]} - {4'd0, cin};
                result = full[7:0];
                h      = half[4];
                c      = full[8];   // Borrow out of bit 7
            end
            alu_and:
            begin
                result = alu_a & alu_b;
                h      = 1'b1;
            end
            alu_xor: result = alu_a ^ alu_b;
            default: result = alu_a | alu_b;    // or
        endcase
    end

    assign z = (result == 8'h00);
    assign n = (alu_op == alu_sub || alu_op == alu_sbc || alu_op == alu_cp);

endmodule

/* hw/control_unit.sv */
`timescale 1ns/100ps

module control_unit (
    input  logic                     clock,
    input  logic                     rst_n,
    input  cpu_isa_pkg::byte_t       rdata,
    input  logic                     flag_z,
    input  logic                     flag_c,
    output logic                     nread,
    output logic                     nwrite,
    output cpu_ctrl_pkg::addr_sel_t  addr_sel,
    output logic                     pc_inc,
    output logic                     pc_load,
    output cpu_isa_pkg::reg_idx_t    rf_rd_a,
    output cpu_isa_pkg::reg_idx_t    rf_rd_b,
    output cpu_isa_pkg::reg_idx_t    rf_wr_idx,
    output logic                     rf_we,
    output cpu_ctrl_pkg::rf_in_sel_t rf_in_sel,
    output cpu_isa_pkg::alu_op_t     alu_op,
    output cpu_ctrl_pkg::alu_b_sel_t alu_b_sel,
    output logic                     flags_we,
    output logic                     lo_we
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    seq_state_t state, state_next;
    byte_t      opcode;
    reg_idx_t   dst, src;
    logic [1:0] grp;
    logic       jump_taken;

    // Where the fetched opcode goes next; unknown opcodes end in fetch
    function automatic seq_state_t after_fetch(byte_t op);
        seq_state_t next;
        next = st_fetch;
        if (op == op_halt)
            next = st_halted;
        else if (op == op_jp || (op & jp_cc_mask) == jp_cc_match)
            next = st_read_lo;
        else if (op[grp_msb:grp_lsb] == grp_ld_reg || op[grp_msb:grp_lsb] == grp_alu_reg)
            next = st_exec;
        else if (op[src_msb:src_lsb] == reg_mem)
        begin
            // ld (HL),n is not supported
            if (op[grp_msb:grp_lsb] == grp_alu_imm || op[dst_msb:dst_lsb] != reg_mem)
                next = st_exec;
        end
        return next;
    endfunction

    assign dst    = opcode[dst_msb:dst_lsb];
    assign src    = opcode[src_msb:src_lsb];
    assign grp    = opcode[grp_msb:grp_lsb];
    assign alu_op = alu_op_t'(dst);

    always_comb
    begin
        if (opcode == op_jp)
            jump_taken = 1'b1;
        else
        begin
            case (cond_t'(opcode[cond_msb:cond_lsb]))
                cond_nz: jump_taken = !flag_z;
                cond_z:  jump_taken = flag_z;
                cond_nc: jump_taken = !flag_c;
                default: jump_taken = flag_c;
            endcase
        end
    end

    always_comb
    begin
        state_next = state;
        nread      = 1'b1;
        nwrite     = 1'b1;
        addr_sel   = addr_pc;
        pc_inc     = 1'b0;
        pc_load    = 1'b0;
        rf_rd_a    = reg_a;
        rf_rd_b    = src;
        rf_wr_idx  = dst;
        rf_we      = 1'b0;
        rf_in_sel  = rf_in_bus;
        alu_b_sel  = alu_b_reg;
        flags_we   = 1'b0;
        lo_we      = 1'b0;
        case (state)
            st_fetch:
            begin
                nread      = !rst_n;    // Bus idle while reset is held
                pc_inc     = 1'b1;
                state_next = after_fetch(rdata);
            end
            st_exec:
            begin
                state_next = st_fetch;
                case (grp)
                    grp_ld_reg:
                    begin
                        if (src == reg_mem)     // ld r,(HL)
                        begin
                            addr_sel = addr_hl;
                            nread    = 1'b0;
                            rf_we    = 1'b1;
                        end
                        else if (dst == reg_mem)    // ld (HL),r
                        begin
                            addr_sel = addr_hl;
                            nwrite   = 1'b0;
                        end
                        else
                        begin
                            rf_in_sel = rf_in_reg;
                            rf_we     = 1'b1;
                        end
                    end
                    grp_ld_imm:
                    begin
                        nread  = 1'b0;
                        pc_inc = 1'b1;
                        rf_we  = 1'b1;
                    end
                    default:
                    begin
                        rf_wr_idx = reg_a;
                        rf_in_sel = rf_in_alu;
                        flags_we  = 1'b1;
                        rf_we     = (alu_op != alu_cp);  // cp only sets flags
                        if (grp == grp_alu_imm)
                        begin
                            nread     = 1'b0;
                            pc_inc    = 1'b1;
                            alu_b_sel = alu_b_bus;
                        end
                        else if (src == reg_mem)
                        begin
                            addr_sel  = addr_hl;
                            nread     = 1'b0;
                            alu_b_sel = alu_b_bus;
                        end
                    end
                endcase
            end
            st_read_lo:
            begin
                nread      = 1'b0;
                pc_inc     = 1'b1;
                lo_we      = 1'b1;
                state_next = st_read_hi;
            end
            st_read_hi:
            begin
                nread      = 1'b0;
                pc_load    = jump_taken;
                pc_inc     = !jump_taken;   // Step past the operand when not taken
                state_next = st_fetch;
            end
            st_halted: state_next = st_halted;
            default:   state_next = st_fetch;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state  <= st_fetch;
            opcode <= 8'h00;
        end
        else
        begin
            state <= state_next;
            if (state == st_fetch)
                opcode <= rdata;
        end
    end

    a_strobes_exclusive: assert property (
        @(posedge clock) disable iff (!rst_n) !(!nread && !nwrite)
    ) else $error("nread and nwrite low together");

endmodule

/* hw/cpu_core.sv */
`timescale 1ns/100ps

module cpu_core #(
    parameter cpu_isa_pkg::addr_t reset_pc = 16'h0000
) (
    input  logic               clock,
    input  logic               rst_n,
    input  cpu_isa_pkg::byte_t rdata,
    output cpu_isa_pkg::addr_t addr,
    output cpu_isa_pkg::byte_t wdata,
    output logic               nread,
    output logic               nwrite
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    addr_sel_t  addr_sel;
    alu_b_sel_t alu_b_sel;
    rf_in_sel_t rf_in_sel;
    alu_op_t    alu_op;
    reg_idx_t   rf_rd_a, rf_rd_b, rf_wr_idx;
    logic       pc_inc, pc_load, rf_we, flags_we, lo_we;
    logic       flag_z, flag_c, carry_in;
    logic       alu_z, alu_n, alu_h, alu_c;
    addr_t      pc, jump_target, hl;
    byte_t      rd_a_data, rd_b_data, rf_wdata, alu_b, alu_result;

    control_unit u_ctrl (
        .clock(clock), .rst_n(rst_n), .rdata(rdata),
        .flag_z(flag_z), .flag_c(flag_c),
        .nread(nread), .nwrite(nwrite), .addr_sel(addr_sel),
        .pc_inc(pc_inc), .pc_load(pc_load),
        .rf_rd_a(rf_rd_a), .rf_rd_b(rf_rd_b), .rf_wr_idx(rf_wr_idx),
        .rf_we(rf_we), .rf_in_sel(rf_in_sel),
        .alu_op(alu_op), .alu_b_sel(alu_b_sel), .flags_we(flags_we), .lo_we(lo_we)
    );

    datapath u_dp (
        .clock(clock), .rst_n(rst_n), .rdata(rdata), .pc(pc),
        .rd_b_data(rd_b_data), .alu_result(alu_result),
        .alu_z(alu_z), .alu_n(alu_n), .alu_h(alu_h), .alu_c(alu_c),
        .addr_sel(addr_sel), .alu_b_sel(alu_b_sel), .rf_in_sel(rf_in_sel),
        .flags_we(flags_we), .lo_we(lo_we), .hl(hl),
        .addr(addr), .wdata(wdata), .alu_b(alu_b), .carry_in(carry_in),
        .rf_wdata(rf_wdata), .jump_target(jump_target),
        .flag_z(flag_z), .flag_c(flag_c)
    );

    pc_unit #(.reset_pc(reset_pc)) u_pc (
        .clock(clock), .rst_n(rst_n), .pc_inc(pc_inc), .pc_load(pc_load),
        .jump_target(jump_target), .pc(pc)
    );

    reg_file u_rf (
        .clock(clock), .rst_n(rst_n),
        .rf_rd_a(rf_rd_a), .rf_rd_b(rf_rd_b), .rf_wr_idx(rf_wr_idx),
        .rf_we(rf_we), .rf_wdata(rf_wdata),
        .rd_a_data(rd_a_data), .rd_b_data(rd_b_data), .hl(hl)
    );

    // Operand A is always the read port A output
    alu u_alu (
        .alu_op(alu_op), .alu_a(rd_a_data), .alu_b(alu_b), .carry_in(carry_in),
        .result(alu_result), .z(alu_z), .n(alu_n), .h(alu_h), .c(alu_c)
    );

endmodule

/* hw/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    // Bus address source
    typedef enum logic {
        addr_pc,
        addr_hl
    } addr_sel_t;

    // ALU operand B source
    typedef enum logic {
        alu_b_reg,
        alu_b_bus
    } alu_b_sel_t;

    // Register file write-back source
    typedef enum logic [1:0] {
        rf_in_bus,
        rf_in_alu,
        rf_in_reg
    } rf_in_sel_t;

    // Micro-sequencer, one bus cycle per state
    typedef enum logic [2:0] {
        st_fetch,
        st_exec,
        st_read_lo,     // Jump target low byte
        st_read_hi,
        st_halted
    } seq_state_t;

endpackage

/* hw/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;
    typedef logic [2:0]  reg_idx_t;

    localparam reg_idx_t reg_b   = 3'd0;
    localparam reg_idx_t reg_c   = 3'd1;
    localparam reg_idx_t reg_d   = 3'd2;
    localparam reg_idx_t reg_e   = 3'd3;
    localparam reg_idx_t reg_h   = 3'd4;
    localparam reg_idx_t reg_l   = 3'd5;
    localparam reg_idx_t reg_mem = 3'd6;    // Byte at (HL), not a register
    localparam reg_idx_t reg_a   = 3'd7;

    // Order matches opcode bits 5:3
    typedef enum logic [2:0] {
        alu_add, alu_adc, alu_sub, alu_sbc,
        alu_and, alu_xor, alu_or, alu_cp
    } alu_op_t;

    typedef enum logic [1:0] {cond_nz, cond_z, cond_nc, cond_c} cond_t;

    // Opcode fields
    localparam int grp_msb  = 7;
    localparam int grp_lsb  = 6;
    localparam int dst_msb  = 5;
    localparam int dst_lsb  = 3;
    localparam int src_msb  = 2;
    localparam int src_lsb  = 0;
    localparam int cond_msb = 4;
    localparam int cond_lsb = 3;

    localparam logic [1:0] grp_ld_imm  = 2'b00;
    localparam logic [1:0] grp_ld_reg  = 2'b01;
    localparam logic [1:0] grp_alu_reg = 2'b10;
    localparam logic [1:0] grp_alu_imm = 2'b11;

    localparam byte_t op_halt     = 8'h76;
    localparam byte_t op_jp       = 8'hC3;
    localparam byte_t jp_cc_mask  = 8'hE7;  // 110cc010 with cc masked out
    localparam byte_t jp_cc_match = 8'hC2;

endpackage

/* hw/datapath.sv */
`timescale 1ns/100ps

module datapath (
    input  logic                     clock,
    input  logic                     rst_n,
    input  cpu_isa_pkg::byte_t       rdata,
    input  cpu_isa_pkg::addr_t       pc,
    input  cpu_isa_pkg::byte_t       rd_b_data,
    input  cpu_isa_pkg::byte_t       alu_result,
    input  logic                     alu_z,
    input  logic                     alu_n,
    input  logic                     alu_h,
    input  logic                     alu_c,
    input  cpu_ctrl_pkg::addr_sel_t  addr_sel,
    input  cpu_ctrl_pkg::alu_b_sel_t alu_b_sel,
    input  cpu_ctrl_pkg::rf_in_sel_t rf_in_sel,
    input  logic                     flags_we,
    input  logic                     lo_we,
    input  cpu_isa_pkg::addr_t       hl,
    output cpu_isa_pkg::addr_t       addr,
    output cpu_isa_pkg::byte_t       wdata,
    output cpu_isa_pkg::byte_t       alu_b,
    output logic                     carry_in,
    output cpu_isa_pkg::byte_t       rf_wdata,
    output cpu_isa_pkg::addr_t       jump_target,
    output logic                     flag_z,
    output logic                     flag_c
);
    import cpu_isa_pkg::*;
    import cpu_ctrl_pkg::*;

    logic [3:0] flags;      // Z N H C
    byte_t      jump_lo;

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
            flags <= 4'b1000;   // Z starts set
        else if (flags_we)
            flags <= {alu_z, alu_n, alu_h, alu_c};
    end

    always_ff @(posedge clock)
    begin
        if (lo_we)
            jump_lo <= rdata;
    end

    assign flag_z   = flags[3];
    assign flag_c   = flags[0];
    assign carry_in = flags[0];

    // High byte comes straight off the bus in read_hi
    assign jump_target = {rdata, jump_lo};

    assign addr  = (addr_sel == addr_hl) ? hl : pc;
    assign alu_b = (alu_b_sel == alu_b_bus) ? rdata : rd_b_data;
    assign wdata = rd_b_data;

    always_comb
    begin
        case (rf_in_sel)
            rf_in_alu: rf_wdata = alu_result;
            rf_in_reg: rf_wdata = rd_b_data;
            default:   rf_wdata = rdata;
        endcase
    end

endmodule

/* hw/pc_unit.sv */
`timescale 1ns/100ps

module pc_unit #(
    parameter cpu_isa_pkg::addr_t reset_pc = 16'h0000
) (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               pc_inc,
    input  logic               pc_load,
    input  cpu_isa_pkg::addr_t jump_target,
    output cpu_isa_pkg::addr_t pc
);

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
            pc <= reset_pc;
        else if (pc_load)
            pc <= jump_target;
        else if (pc_inc)
            pc <= pc + 16'd1;   // Wraps at 0xFFFF
    end

    // The sequencer chooses one PC source per cycle
    a_pc_one_source: assert property (
        @(posedge clock) disable iff (!rst_n) !(pc_inc && pc_load)
    ) else $error("pc_inc and pc_load high together");

endmodule

/* hw/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input  logic                  clock,
    input  logic                  rst_n,
    input  cpu_isa_pkg::reg_idx_t rf_rd_a,
    input  cpu_isa_pkg::reg_idx_t rf_rd_b,
    input  cpu_isa_pkg::reg_idx_t rf_wr_idx,
    input  logic                  rf_we,
    input  cpu_isa_pkg::byte_t    rf_wdata,
    output cpu_isa_pkg::byte_t    rd_a_data,
    output cpu_isa_pkg::byte_t    rd_b_data,
    output cpu_isa_pkg::addr_t    hl
);
    import cpu_isa_pkg::*;

    byte_t regs [7];

    // A takes the slot left free by index 6
    function automatic logic [2:0] slot(reg_idx_t idx);
        return (idx == reg_a) ? 3'd6 : idx;
    endfunction

    function automatic byte_t read_port(reg_idx_t idx);
        return (idx == reg_mem) ? 8'h00 : regs[slot(idx)];
    endfunction

    assign rd_a_data = read_port(rf_rd_a);
    assign rd_b_data = read_port(rf_rd_b);
    assign hl        = {regs[reg_h], regs[reg_l]};

    always_ff @(posedge clock or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < 7; i++)
                regs[i] <= 8'h00;
        end
        else if (rf_we && rf_wr_idx != reg_mem)
            regs[slot(rf_wr_idx)] <= rf_wdata;
    end

    // Memory operand goes out on the bus, never into the file
    a_no_mem_write: assert property (
        @(posedge clock) disable iff (!rst_n) rf_we |-> rf_wr_idx != reg_mem
    ) else $error("register write to index 6");

endmodule

/* run_sim.sh */
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_cpu_core -f sources.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_cpu_core > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$log"; then
    exit 1
fi
exit 0

/* sources.f */
+incdir+test
hw/cpu_isa_pkg.sv
hw/cpu_ctrl_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/pc_unit.sv
hw/datapath.sv
hw/control_unit.sv
hw/cpu_core.sv
test/tb_cpu_core.sv

/* test/cpu_tests.svh */
task automatic test_loads_stores();
    begin_test();
    for (int i = 0; i < 5; i++)
        ld_imm(data_regs[i], 8'($random(seed)));
    ld_imm(reg_h, 8'h80);
    for (int i = 0; i < 5; i++)
    begin
        ld_imm(reg_l, 8'(8'h10 + i));
        st_to_hl(data_regs[i]);
    end
    ld_imm(reg_l, 8'h20);
    st_to_hl(reg_h);
    st_to_hl(reg_l);
    // Rotate values through the registers
    ld_reg(reg_a, reg_b);
    ld_reg(reg_b, reg_c);
    ld_reg(reg_c, reg_d);
    ld_reg(reg_d, reg_e);
    ld_reg(reg_e, reg_a);
    ld_imm(reg_h, 8'h90);
    for (int i = 0; i < 5; i++)
    begin
        ld_imm(reg_l, 8'(8'h30 + i));
        st_to_hl(data_regs[i]);
    end
    emit(op_halt);
    run_program("loads_stores");
endtask

task automatic test_alu_ops();
    alu_op_t  op;
    reg_idx_t src;
    begin_test();
    ld_imm(reg_h, 8'h81);
    for (int i = 0; i < 8; i++)
    begin
        op  = alu_op_t'(3'(i));
        src = data_regs[i % 5];
        ld_imm(reg_a, 8'($random(seed)));
        alu_imm(op, 8'($random(seed)));
        ld_imm(reg_l, 8'(2 * i));
        st_to_hl(reg_a);
        ld_imm(src, 8'($random(seed)));
        alu_reg(op, src);   // Carry from the previous op feeds adc and sbc
        ld_imm(reg_l, 8'(2 * i + 1));
        st_to_hl(reg_a);
    end
    emit(op_halt);
    run_program("alu_ops");
endtask

task automatic test_mem_operands();
    begin_test();
    for (int i = 0; i < 11; i++)
        place_byte(16'h4000 + 16'(i), 8'($random(seed)));
    ld_imm(reg_h, 8'h40);
    ld_imm(reg_l, 8'h08);
    ld_from_hl(reg_a);
    ld_imm(reg_l, 8'h09);
    ld_from_hl(reg_c);
    ld_imm(reg_l, 8'h0A);
    ld_from_hl(reg_d);
    for (int i = 0; i < 8; i++)
    begin
        ld_imm(reg_l, 8'(i));
        alu_hl(alu_op_t'(3'(i)));
        ld_imm(reg_l, 8'(8'h80 + i));
        st_to_hl(reg_a);
    end
    ld_imm(reg_l, 8'h90);
    st_to_hl(reg_c);
    ld_imm(reg_l, 8'h91);
    st_to_hl(reg_d);
    emit(op_halt);
    run_program("mem_operands");
endtask

// Taken path stores C, fall-through stores B then jumps over the other store
task automatic test_cond_jumps();
    cond_t cc;
    byte_t x;
    byte_t y;
    addr_t at;
    begin_test();
    ld_imm(reg_h, 8'h70);
    ld_imm(reg_b, 8'h11);
    ld_imm(reg_c, 8'h22);
    for (int i = 0; i < 8; i++)
    begin
        cc = cond_t'(2'(i / 2));
        x  = 8'($random(seed)) & 8'h7F;
        y  = x;
        if (pair_kind[i] == 1)
            y = x + 8'h80;
        else if (pair_kind[i] == 2)
            x = x + 8'h80;
        ld_imm(reg_l, 8'(i));
        ld_imm(reg_a, x);
        alu_imm(alu_cp, y);
        at = emit_ptr;
        jp_emit({3'b110, cc, 3'b010}, at + 16'd7);
        if (cond_holds(cc))
            expect_write({8'h70, 8'(i)}, 8'h22);
        else
            expect_write({8'h70, 8'(i)}, 8'h11);
        emit({2'b01, reg_mem, reg_b});
        jp_emit(op_jp, at + 16'd8);
        emit({2'b01, reg_mem, reg_c});
    end
    emit(op_halt);
    run_program("cond_jumps");
endtask

task automatic test_jump_halt();
    begin_test();
    ld_imm(reg_h, 8'h60);
    ld_imm(reg_l, 8'h00);
    ld_imm(reg_b, 8'($random(seed)));
    ld_imm(reg_c, 8'($random(seed)));
    st_to_hl(reg_b);
    jp_emit(op_jp, 16'h2345);
    emit({2'b01, reg_mem, reg_c});     // Skipped by the jump
    emit(op_halt);
    emit_ptr = 16'h2345;
    ld_imm(reg_l, 8'h01);
    st_to_hl(reg_c);
    emit(op_halt);
    emit({2'b01, reg_mem, reg_b});     // Never reached
    run_program("jump_halt");
endtask

/* test/tb_cpu_core.sv */
`timescale 1ns/100ps

module tb_cpu_core;
    import cpu_isa_pkg::*;

    localparam addr_t start_pc     = 16'h0100;
    localparam int    clock_period = 20;
    localparam int    reset_cycles = 16;
    localparam int    num_tests    = 5;
    localparam int    test_cycles  = 200;
    localparam int    halt_limit   = test_cycles - reset_cycles - 16;

    localparam reg_idx_t data_regs [5] = '{reg_b, reg_c, reg_d, reg_e, reg_a};

    // Compare kind per jump case (0 equal, 1 A below n, 2 A above n)
    localparam int pair_kind [8] = '{0, 2, 0, 2, 1, 0, 1, 2};

    logic  clock;
    logic  rst_n;
    byte_t rdata;
    addr_t addr;
    byte_t wdata;
    logic  nread;
    logic  nwrite;

    byte_t mem [65536];
    addr_t got_addr [$];
    byte_t got_data [$];
    addr_t exp_addr [$];
    byte_t exp_data [$];

    // Reference machine advanced as each instruction is emitted
    byte_t model [8];
    byte_t ref_mem [65536];
    logic  ref_z;
    logic  ref_c;
    addr_t emit_ptr;

    integer seed;
    int     errors;
    int     tests_run;
    int     test_start_errors;

    cpu_core #(.reset_pc(start_pc)) DUT (
        .clock(clock), .rst_n(rst_n), .rdata(rdata), .addr(addr),
        .wdata(wdata), .nread(nread), .nwrite(nwrite)
    );

    always #(clock_period / 2) clock = ~clock;

    assign rdata = nread ? 8'hFF : mem[addr];

    always @(posedge clock)
    begin
        if (rst_n && !nwrite)
        begin
            mem[addr] <= wdata;
            got_addr.push_back(addr);
            got_data.push_back(wdata);
        end
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        if (got !== exp)
        begin
            $display("mismatch %s: got %0h, expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic emit(input byte_t b);
        mem[emit_ptr] <= b;
        emit_ptr = emit_ptr + 16'd1;
    endtask

    task automatic place_byte(input addr_t a, input byte_t d);
        mem[a] <= d;
        ref_mem[a] = d;
    endtask

    task automatic expect_write(input addr_t a, input byte_t d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    function automatic addr_t model_hl();
        return {model[reg_h], model[reg_l]};
    endfunction

    task automatic ld_imm(input reg_idx_t r, input byte_t n);
        emit({2'b00, r, 3'b110});
        emit(n);
        model[r] = n;
    endtask

    task automatic ld_reg(input reg_idx_t d, input reg_idx_t s);
        emit({2'b01, d, s});
        model[d] = model[s];
    endtask

    task automatic ld_from_hl(input reg_idx_t d);
        emit({2'b01, d, reg_mem});
        model[d] = ref_mem[model_hl()];
    endtask

    task automatic st_to_hl(input reg_idx_t s);
        emit({2'b01, reg_mem, s});
        ref_mem[model_hl()] = model[s];
        expect_write(model_hl(), model[s]);
    endtask

    // Flag and result rules of the instruction set
    task automatic apply_alu(input alu_op_t op, input byte_t b);
        int a;
        int r;
        int ci;
        a  = int'(model[reg_a]);
        ci = (op == alu_adc || op == alu_sbc) ? int'(ref_c) : 0;
        case (op)
            alu_add, alu_adc:         r = a + int'(b) + ci;
            alu_sub, alu_sbc, alu_cp: r = a - int'(b) - ci;
            alu_and:                  r = a & int'(b);
            alu_xor:                  r = a ^ int'(b);
            default:                  r = a | int'(b);
        endcase
        ref_c = (r < 0 || r > 255);
        ref_z = ((r & 255) == 0);
        if (op != alu_cp)
            model[reg_a] = 8'(r);
    endtask

    task automatic alu_imm(input alu_op_t op, input byte_t n);
        emit({2'b11, op, 3'b110});
        emit(n);
        apply_alu(op, n);
    endtask

    task automatic alu_reg(input alu_op_t op, input reg_idx_t s);
        emit({2'b10, op, s});
        apply_alu(op, model[s]);
    endtask

    task automatic alu_hl(input alu_op_t op);
        emit({2'b10, op, reg_mem});
        apply_alu(op, ref_mem[model_hl()]);
    endtask

    task automatic jp_emit(input byte_t opcode, input addr_t target);
        emit(opcode);
        emit(target[7:0]);     // Low byte first
        emit(target[15:8]);
    endtask

    function automatic logic cond_holds(input cond_t cc);
        logic taken;
        case (cc)
            cond_nz: taken = !ref_z;
            cond_z:  taken = ref_z;
            cond_nc: taken = !ref_c;
            default: taken = ref_c;
        endcase
        return taken;
    endfunction

    task automatic begin_test();
        @(posedge clock);
        rst_n <= 1'b0;
        for (int i = 0; i < 65536; i++)
        begin
            mem[i] <= 8'(i) ^ 8'(i >> 8);
            ref_mem[i] = 8'(i) ^ 8'(i >> 8);
        end
        for (int i = 0; i < 8; i++)
            model[i] = 8'h00;
        ref_z    = 1'b1;   // Flags after reset
        ref_c    = 1'b0;
        emit_ptr = start_pc;
        got_addr.delete();
        got_data.delete();
        exp_addr.delete();
        exp_data.delete();
        test_start_errors = errors;
    endtask

    task automatic compare_writes(input string name);
        for (int i = 0; i < got_addr.size() || i < exp_addr.size(); i++)
        begin
            if (i >= got_addr.size())
                report_error($sformatf("%s: missing write of %h to address %h",
                                       name, exp_data[i], exp_addr[i]));
            else if (i >= exp_addr.size())
                report_error($sformatf("%s: unexpected write of %h to address %h",
                                       name, got_data[i], got_addr[i]));
            else
            begin
                check_value("addr", got_addr[i], exp_addr[i]);
                check_value("wdata", 16'(got_data[i]), 16'(exp_data[i]));
            end
        end
    endtask

    // Release reset, wait for halt, then watch the idle bus
    task automatic run_program(input string name);
        int quiet;
        int cycles;
        int writes_at_halt;
        quiet  = 0;
        cycles = 0;
        repeat (reset_cycles)
        begin
            @(negedge clock);
            check_value("nread", 16'(nread), 16'h0001);
            check_value("nwrite", 16'(nwrite), 16'h0001);
        end
        @(posedge clock);
        rst_n <= 1'b1;
        while (quiet < 4 && cycles < halt_limit)
        begin
            @(negedge clock);
            cycles++;
            if (nread)
                quiet++;
            else
                quiet = 0;
        end
        if (quiet < 4)
            report_error($sformatf("%s did not reach halt within %0d cycles",
                                   name, halt_limit));
        else
        begin
            writes_at_halt = got_addr.size();
            repeat (8)
            begin
                @(negedge clock);
                check_value("nread", 16'(nread), 16'h0001);
                check_value("nwrite", 16'(nwrite), 16'h0001);
            end
            if (got_addr.size() != writes_at_halt)
                report_error($sformatf("%s wrote to memory after halt", name));
        end
        compare_writes(name);
        tests_run++;
        $display("test %s finished: %0d writes expected, %0d errors",
                 name, exp_addr.size(), errors - test_start_errors);
    endtask

    `include "cpu_tests.svh"

    initial
    begin
        seed      = 50;
        clock     = 1'b0;
        rst_n     = 1'b0;
        errors    = 0;
        tests_run = 0;
        repeat (reset_cycles) @(posedge clock);
        test_loads_stores();
        test_alu_ops();
        test_mem_operands();
        test_cond_jumps();
        test_jump_halt();
        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        #((num_tests * test_cycles + reset_cycles) * clock_period);
        $display("watchdog expired before all tests finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule
